/* biu_pkg.sv */
//////////////////////////////
// Shared widths, attribute encodings and memory depth for the
// data memory path. Imported by every module of the data side,
// the two bus interfaces and the testbench
//////////////////////////////

package biu_pkg;

  //////////////////////////////
  // Widths

  // Data word width
  localparam int XLEN = 32;

  // Physical address width
  localparam int PLEN = 32;

  // One write strobe per byte lane
  localparam int STRB_W = XLEN / 8;

  //////////////////////////////
  // On-chip RAM

  // Depth in words, higher word addresses give SLVERR
  localparam int MEM_WORDS = 256;

  // Word index bits inside the RAM
  localparam int MEM_AW = $clog2(MEM_WORDS);

  //////////////////////////////
  // Request attributes

  // Transfer size; DWORD is reserved on a 32 bit path and is rejected
  typedef enum logic [2:0] {
    BYTE  = 3'b000,
    HWORD = 3'b001,
    WORD  = 3'b010,
    DWORD = 3'b011
  } biu_size_t;

  // Burst type, only SINGLE is served
  typedef enum logic [2:0] {
    SINGLE = 3'b000,
    INCR   = 3'b001,
    WRAP4  = 3'b010,
    INCR4  = 3'b011,
    WRAP8  = 3'b100,
    INCR8  = 3'b101,
    WRAP16 = 3'b110,
    INCR16 = 3'b111
  } biu_type_t;

  // Protection, bit for bit the same as AxPROT
  typedef struct packed {
    logic instr;   // bit 2, instruction access
    logic nonsec;  // bit 1, non-secure access
    logic priv;    // bit 0, privileged access
  } biu_prot_t;

  //////////////////////////////
  // AXI response codes
  localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
  localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

endpackage

/* biu_if.sv */
//////////////////////////////
// Strobe/acknowledge link between the request holding stage
// and the bus interface unit. A request moves when stb and
// stb_ack are both high; ack pulses once per transfer
//////////////////////////////

interface biu_if import biu_pkg::*; ();

  // Request strobe and its acceptance
  logic            stb;
  logic            stb_ack;

  // Request attributes and write data
  logic [PLEN-1:0] adr;
  biu_size_t       size;
  biu_type_t       btype;
  biu_prot_t       prot;
  logic            we;
  logic [XLEN-1:0] d;

  // Response, q and err qualified by ack
  logic [XLEN-1:0] q;
  logic            ack;
  logic            err;

  // Request side
  modport dext (
    output stb, adr, size, btype, prot, we, d,
    input  stb_ack, q, ack, err
  );

  // Bus interface side
  modport biu (
    input  stb, adr, size, btype, prot, we, d,
    output stb_ack, q, ack, err
  );

endinterface

/* axi_lite_if.sv */
//////////////////////////////
// AXI4-Lite bundle with the five channels.
// The master modport goes to the bus interface unit,
// the slave modport to the on-chip RAM
//////////////////////////////

interface axi_lite_if import biu_pkg::*; ();

  // Write address channel
  logic              awvalid;
  logic              awready;
  logic [PLEN-1:0]   awaddr;
  logic [2:0]        awprot;

  // Write data channel
  logic              wvalid;
  logic              wready;
  logic [XLEN-1:0]   wdata;
  logic [STRB_W-1:0] wstrb;

  // Write response channel
  logic              bvalid;
  logic              bready;
  logic [1:0]        bresp;

  // Read address channel
  logic              arvalid;
  logic              arready;
  logic [PLEN-1:0]   araddr;
  logic [2:0]        arprot;

  // Read data channel
  logic              rvalid;
  logic              rready;
  logic [XLEN-1:0]   rdata;
  logic [1:0]        rresp;

  modport master (
    output awvalid, awaddr, awprot, wvalid, wdata, wstrb, bready,
    output arvalid, araddr, arprot, rready,
    input  awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
  );

  modport slave (
    input  awvalid, awaddr, awprot, wvalid, wdata, wstrb, bready,
    input  arvalid, araddr, arprot, rready,
    output awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
  );

endinterface

/* data_ext_access.sv */
//////////////////////////////
// CPU data port front end. Passes a load/store straight to
// the bus interface when it is accepted at once, otherwise
// keeps a copy and presents it until stb_ack
//////////////////////////////

module data_ext_access import biu_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,

  // CPU side
  input  logic            mem_req_i,
  input  logic [PLEN-1:0] mem_adr_i,
  input  biu_size_t       mem_size_i,
  input  biu_type_t       mem_type_i,
  input  biu_prot_t       mem_prot_i,
  input  logic            mem_we_i,
  input  logic [XLEN-1:0] mem_d_i,
  output logic [XLEN-1:0] mem_q_o,
  output logic            mem_ack_o,
  output logic            mem_err_o,

  // Towards the bus interface unit
  biu_if.dext             biu
);

  // Pending request not yet taken by the BIU
  logic            hold_req;

  // Copy of the last request
  logic [PLEN-1:0] hold_adr;
  biu_size_t       hold_size;
  biu_type_t       hold_type;
  biu_prot_t       hold_prot;
  logic            hold_we;
  logic [XLEN-1:0] hold_d;

  //////////////////////////////
  // Request capture

  // Every new request is copied, only used when not taken at once
  always_ff @(posedge clk_i)
  begin
    if (mem_req_i)
    begin
      hold_adr  <= mem_adr_i;
      hold_size <= mem_size_i;
      hold_type <= mem_type_i;
      hold_prot <= mem_prot_i;
      hold_we   <= mem_we_i;
      hold_d    <= mem_d_i;
    end
  end

  // Set by a request the BIU did not accept, dropped on stb_ack
  always_ff @(posedge clk_i)
  begin
    if (!rst_ni)
      hold_req <= 1'b0;
    else
      hold_req <= (mem_req_i | hold_req) & ~biu.stb_ack;
  end

  //////////////////////////////
  // Strobe side, held copy wins over the live inputs
  assign biu.stb   = mem_req_i | hold_req;
  assign biu.adr   = hold_req ? hold_adr  : mem_adr_i;
  assign biu.size  = hold_req ? hold_size : mem_size_i;
  assign biu.btype = hold_req ? hold_type : mem_type_i;
  assign biu.prot  = hold_req ? hold_prot : mem_prot_i;
  assign biu.we    = hold_req ? hold_we   : mem_we_i;
  assign biu.d     = hold_req ? hold_d    : mem_d_i;

  // Response goes back to the CPU unchanged
  assign mem_q_o   = biu.q;
  assign mem_ack_o = biu.ack;
  assign mem_err_o = biu.err;

endmodule

/* biu_axi_lite.sv */
//////////////////////////////
// Bus interface unit. Takes one strobe request at a time and
// runs it as a single AXI4-Lite read or write. Bad burst type,
// reserved size or misalignment is answered locally
//////////////////////////////

module biu_axi_lite import biu_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  biu_if.biu         biu,
  axi_lite_if.master axi
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BUS,
    ST_LERR
  } state_t;

  state_t            state_q;
  state_t            state_d;

  // Request accepted in this cycle
  logic              accept;
  logic              align_err;
  logic              local_err;

  // Address and write data phases already done
  logic              adr_done_q;
  logic              w_done_q;

  // Bus response seen for the current transfer
  logic              bus_resp;
  logic [1:0]        resp;

  // Latched request
  logic [PLEN-1:0]   req_adr_q;
  logic [XLEN-1:0]   req_d_q;
  biu_size_t         req_size_q;
  biu_prot_t         req_prot_q;
  logic              req_we_q;
  logic [STRB_W-1:0] wstrb;

  //////////////////////////////
  // Acceptance and local checks

  // Only idle takes a new request
  assign biu.stb_ack = (state_q == ST_IDLE);
  assign accept      = biu.stb & biu.stb_ack;

  // Natural alignment per size, reserved sizes fail
  always_comb
  begin
    case (biu.size)
      BYTE:    align_err = 1'b0;
      HWORD:   align_err = biu.adr[0];
      WORD:    align_err = |biu.adr[1:0];
      default: align_err = 1'b1;
    endcase
  end

  assign local_err = align_err | (biu.btype != SINGLE);

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      req_adr_q  <= biu.adr;
      req_d_q    <= biu.d;
      req_size_q <= biu.size;
      req_prot_q <= biu.prot;
      req_we_q   <= biu.we;
    end
  end

  //////////////////////////////
  // FSM
  always_ff @(posedge clk_i)
  begin
    if (!rst_ni)
      state_q <= ST_IDLE;
    else
      state_q <= state_d;
  end

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:
        if (accept)
          state_d = local_err ? ST_LERR : ST_BUS;
      ST_BUS:
        if (bus_resp)
          state_d = ST_IDLE;
      default:
        state_d = ST_IDLE;
    endcase
  end

  // Phase flags cleared whenever not on the bus
  always_ff @(posedge clk_i)
  begin
    if (!rst_ni || state_q != ST_BUS)
    begin
      adr_done_q <= 1'b0;
      w_done_q   <= 1'b0;
    end
    else
    begin
      if ((axi.awvalid && axi.awready) || (axi.arvalid && axi.arready))
        adr_done_q <= 1'b1;
      if (axi.wvalid && axi.wready)
        w_done_q <= 1'b1;
    end
  end

  //////////////////////////////
  // AXI channels

  // Byte lanes from size and low address bits
  always_comb
  begin
    case (req_size_q)
      BYTE:    wstrb = STRB_W'(1) << req_adr_q[1:0];
      HWORD:   wstrb = STRB_W'(3) << {req_adr_q[1], 1'b0};
      default: wstrb = '1;
    endcase
  end

  assign axi.awvalid = (state_q == ST_BUS) & req_we_q & ~adr_done_q;
  assign axi.awaddr  = req_adr_q;
  assign axi.awprot  = req_prot_q;
  assign axi.wvalid  = (state_q == ST_BUS) & req_we_q & ~w_done_q;
  assign axi.wdata   = req_d_q;
  assign axi.wstrb   = wstrb;
  assign axi.arvalid = (state_q == ST_BUS) & ~req_we_q & ~adr_done_q;
  assign axi.araddr  = req_adr_q;
  assign axi.arprot  = req_prot_q;

  // Responses always taken
  assign axi.bready = 1'b1;
  assign axi.rready = 1'b1;

  //////////////////////////////
  // Response to the request side
  assign bus_resp = (state_q == ST_BUS) & (req_we_q ? axi.bvalid : axi.rvalid);
  assign resp     = req_we_q ? axi.bresp : axi.rresp;

  assign biu.ack = bus_resp | (state_q == ST_LERR);
  assign biu.err = (state_q == ST_LERR) | (bus_resp & (resp == AXI_RESP_SLVERR));
  assign biu.q   = axi.rdata;

endmodule

/* axi_lite_ram.sv */
//////////////////////////////
// AXI4-Lite slave RAM of MEM_WORDS words. Byte-lane writes,
// whole-word reads, one response per channel in flight.
// Word addresses past the end give SLVERR
//////////////////////////////

module axi_lite_ram import biu_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  axi_lite_if.slave axi
);

  // Storage, contents undefined after reset
  logic [XLEN-1:0]   mem [MEM_WORDS];

  // Handshakes on the address channels
  logic              aw_hs;
  logic              ar_hs;

  // Range check and word index per direction
  logic              aw_in_range;
  logic              ar_in_range;
  logic [MEM_AW-1:0] aw_idx;
  logic [MEM_AW-1:0] ar_idx;

  //////////////////////////////
  // Write side

  // AW and W taken together, and only with no B pending
  assign axi.awready = ~axi.bvalid & axi.awvalid & axi.wvalid;
  assign axi.wready  = axi.awready;
  assign aw_hs       = axi.awvalid & axi.awready;

  assign aw_in_range = (axi.awaddr[PLEN-1:2] < MEM_WORDS);
  assign aw_idx      = axi.awaddr[MEM_AW+1:2];

  // Only lanes with a strobe are updated
  always_ff @(posedge clk_i)
  begin
    if (aw_hs && aw_in_range)
    begin
      for (int i = 0; i < STRB_W; i++)
      begin
        if (axi.wstrb[i])
          mem[aw_idx][8*i +: 8] <= axi.wdata[8*i +: 8];
      end
    end
  end

  // B one cycle after the address handshake
  always_ff @(posedge clk_i)
  begin
    if (!rst_ni)
      axi.bvalid <= 1'b0;
    else if (aw_hs)
      axi.bvalid <= 1'b1;
    else if (axi.bready)
      axi.bvalid <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (aw_hs)
      axi.bresp <= aw_in_range ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
  end

  //////////////////////////////
  // Read side

  // New read only once the previous R beat is gone
  assign axi.arready = ~axi.rvalid;
  assign ar_hs       = axi.arvalid & axi.arready;

  assign ar_in_range = (axi.araddr[PLEN-1:2] < MEM_WORDS);
  assign ar_idx      = axi.araddr[MEM_AW+1:2];

  always_ff @(posedge clk_i)
  begin
    if (!rst_ni)
      axi.rvalid <= 1'b0;
    else if (ar_hs)
      axi.rvalid <= 1'b1;
    else if (axi.rready)
      axi.rvalid <= 1'b0;
  end

  // Out of range reads return zero
  always_ff @(posedge clk_i)
  begin
    if (ar_hs)
    begin
      axi.rdata <= ar_in_range ? mem[ar_idx] : '0;
      axi.rresp <= ar_in_range ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
    end
  end

endmodule

/* data_mem_subsys.sv */
//////////////////////////////
// Data memory path top level. CPU load/store port in,
// through the request stage and the AXI4-Lite BIU
// into the on-chip RAM
//////////////////////////////

module data_mem_subsys import biu_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,

  // CPU data port
  input  logic            mem_req_i,
  input  logic [PLEN-1:0] mem_adr_i,
  input  biu_size_t       mem_size_i,
  input  biu_type_t       mem_type_i,
  input  biu_prot_t       mem_prot_i,
  input  logic            mem_we_i,
  input  logic [XLEN-1:0] mem_d_i,
  output logic [XLEN-1:0] mem_q_o,
  output logic            mem_ack_o,
  output logic            mem_err_o
);

  // Request stage to BIU
  biu_if      biu_bus ();

  // BIU to RAM
  axi_lite_if axi_bus ();

  data_ext_access data_ext_access_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .mem_req_i  (mem_req_i),
    .mem_adr_i  (mem_adr_i),
    .mem_size_i (mem_size_i),
    .mem_type_i (mem_type_i),
    .mem_prot_i (mem_prot_i),
    .mem_we_i   (mem_we_i),
    .mem_d_i    (mem_d_i),
    .mem_q_o    (mem_q_o),
    .mem_ack_o  (mem_ack_o),
    .mem_err_o  (mem_err_o),
    .biu        (biu_bus.dext)
  );

  biu_axi_lite biu_axi_lite_i (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .biu    (biu_bus.biu),
    .axi    (axi_bus.master)
  );

  axi_lite_ram axi_lite_ram_i (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .axi    (axi_bus.slave)
  );

endmodule

/* data_mem_subsys_properties.sv */
//////////////////////////////
// Handshake checks on the data memory path, bound into
// the top level. CPU side ack rules and AXI valid hold
//////////////////////////////

module data_mem_subsys_properties (
  input logic clk_i,
  input logic rst_ni,
  input logic mem_req_i,
  input logic mem_ack_i,
  input logic awvalid_i,
  input logic awready_i,
  input logic wvalid_i,
  input logic wready_i,
  input logic arvalid_i,
  input logic arready_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // Number of assertion failures so far
  int fail_count = 0;

  // Ack is a single cycle pulse
  ack_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_ack_i |=> !mem_ack_i)
  else
  begin
    $error("mem_ack_o high in two consecutive cycles");
    fail_count++;
  end

  // A request is answered within 3 cycles
  req_answered: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_i |-> ##[1:3] mem_ack_i)
  else
  begin
    $error("request without mem_ack_o within 3 cycles");
    fail_count++;
  end

  // No ack without a recent request
  ack_has_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_ack_i |-> ($past(mem_req_i, 1) || $past(mem_req_i, 2) || $past(mem_req_i, 3)))
  else
  begin
    $error("mem_ack_o with no request in the last 3 cycles");
    fail_count++;
  end

  //////////////////////////////
  // AXI valids held until ready
  aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    awvalid_i && !awready_i |=> awvalid_i)
  else
  begin
    $error("AWVALID dropped before AWREADY");
    fail_count++;
  end

  w_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wvalid_i && !wready_i |=> wvalid_i)
  else
  begin
    $error("WVALID dropped before WREADY");
    fail_count++;
  end

  ar_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    arvalid_i && !arready_i |=> arvalid_i)
  else
  begin
    $error("ARVALID dropped before ARREADY");
    fail_count++;
  end

endmodule

bind data_mem_subsys data_mem_subsys_properties props_i (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .mem_req_i (mem_req_i),
  .mem_ack_i (mem_ack_o),
  .awvalid_i (axi_bus.awvalid),
  .awready_i (axi_bus.awready),
  .wvalid_i  (axi_bus.wvalid),
  .wready_i  (axi_bus.wready),
  .arvalid_i (axi_bus.arvalid),
  .arready_i (axi_bus.arready)
);

/* tb_clk_gen.sv */
//////////////////////////////
// Testbench clock and reset. 4 ns clock, active low
// reset held for 8 rising edges, released on an edge
//////////////////////////////

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RST_CYCLES = 8;

  initial
  begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Synchronous release on a rising edge
  initial
  begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

/* data_mem_subsys_tb.sv */
//////////////////////////////
// Table-driven testbench for the data memory path. Each entry
// is one CPU access; expected values come from a byte-lane
// model of the RAM, updated while the table is filled
//////////////////////////////

module data_mem_subsys_tb import biu_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  // Table length, reset length and cycle budget
  localparam int N_TESTS    = 21;
  localparam int RST_CYCLES = 8;
  localparam int TIMEOUT    = N_TESTS * 8 + RST_CYCLES;

  typedef struct {
    logic            we;
    logic [PLEN-1:0] adr;
    biu_size_t       size;
    biu_type_t       btype;
    biu_prot_t       prot;
    logic [XLEN-1:0] d;
    logic [XLEN-1:0] exp_q;
    logic            exp_err;
    logic            chk_q;
    int              exp_lat;
  } test_t;

  logic            clk;
  logic            rst_n;
  logic            mem_req;
  logic [PLEN-1:0] mem_adr;
  biu_size_t       mem_size;
  biu_type_t       mem_type;
  biu_prot_t       mem_prot;
  logic            mem_we;
  logic [XLEN-1:0] mem_d;
  logic [XLEN-1:0] mem_q;
  logic            mem_ack;
  logic            mem_err;

  test_t           tests [N_TESTS];
  logic [XLEN-1:0] ref_mem [MEM_WORDS];
  int              n_fill = 0;
  int              seed = 33;
  int              errors = 0;
  int              passed = 0;
  int              ack_count = 0;
  int              cycles = 0;

  tb_clk_gen clk_gen_i (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  data_mem_subsys data_mem_subsys_i (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .mem_req_i  (mem_req),
    .mem_adr_i  (mem_adr),
    .mem_size_i (mem_size),
    .mem_type_i (mem_type),
    .mem_prot_i (mem_prot),
    .mem_we_i   (mem_we),
    .mem_d_i    (mem_d),
    .mem_q_o    (mem_q),
    .mem_ack_o  (mem_ack),
    .mem_err_o  (mem_err)
  );

  //////////////////////////////
  // Table and reference model

  // Random data and prot, expected response from the access rules
  task automatic add_entry(input logic we, input logic [PLEN-1:0] adr,
                           input biu_size_t size, input biu_type_t btype);
    test_t           t;
    logic [XLEN-1:0] rnd;
    logic [3:0]      lanes;
    logic            bad_local;
    logic            out_range;
    rnd       = $random(seed);
    t.we      = we;
    t.adr     = adr;
    t.size    = size;
    t.btype   = btype;
    t.d       = rnd;
    t.prot    = rnd[31:29];
    // Byte lanes touched by the access
    case (size)
      BYTE:    lanes = 4'b0001 << adr[1:0];
      HWORD:   lanes = adr[1] ? 4'b1100 : 4'b0011;
      default: lanes = 4'b1111;
    endcase
    bad_local = (btype != SINGLE) || !(size inside {BYTE, HWORD, WORD})
                || (size == HWORD && adr[0]) || (size == WORD && adr[1:0] != 2'b00);
    out_range = (adr[PLEN-1:2] >= MEM_WORDS);
    t.exp_err = bad_local | out_range;
    t.exp_lat = bad_local ? 1 : 2;
    // Read data is not defined for a write or a local error
    t.chk_q   = !we && !bad_local;
    t.exp_q   = '0;
    if (!bad_local && !out_range)
    begin
      if (we)
      begin
        for (int i = 0; i < 4; i++)
          if (lanes[i])
            ref_mem[adr[MEM_AW+1:2]][8*i +: 8] = t.d[8*i +: 8];
      end
      else
        t.exp_q = ref_mem[adr[MEM_AW+1:2]];
    end
    tests[n_fill] = t;
    n_fill++;
  endtask

  task automatic build_table();
    // Word write and read back
    add_entry(1'b1, 32'h10, WORD, SINGLE);
    add_entry(1'b0, 32'h10, WORD, SINGLE);
    // Known word, then byte and halfword lanes
    add_entry(1'b1, 32'h20, WORD, SINGLE);
    add_entry(1'b1, 32'h21, BYTE, SINGLE);
    add_entry(1'b1, 32'h23, BYTE, SINGLE);
    add_entry(1'b1, 32'h22, HWORD, SINGLE);
    add_entry(1'b0, 32'h20, WORD, SINGLE);
    add_entry(1'b1, 32'h20, HWORD, SINGLE);
    add_entry(1'b0, 32'h20, WORD, SINGLE);
    // Local errors leave the word alone
    add_entry(1'b1, 32'h30, WORD, SINGLE);
    add_entry(1'b1, 32'h31, WORD, SINGLE);
    add_entry(1'b1, 32'h33, HWORD, SINGLE);
    add_entry(1'b1, 32'h30, DWORD, SINGLE);
    add_entry(1'b1, 32'h30, WORD, INCR);
    add_entry(1'b0, 32'h30, WORD, SINGLE);
    add_entry(1'b0, 32'h31, HWORD, SINGLE);
    // First word past the RAM
    add_entry(1'b1, 32'h400, WORD, SINGLE);
    add_entry(1'b0, 32'h400, WORD, SINGLE);
    // Last word, byte read returns the whole word
    add_entry(1'b1, 32'h3fc, WORD, SINGLE);
    add_entry(1'b0, 32'h3fc, WORD, SINGLE);
    add_entry(1'b0, 32'h3fd, BYTE, SINGLE);
  endtask

  //////////////////////////////
  // Ack counter and timeout
  always @(negedge clk)
    if (rst_n && mem_ack)
      ack_count++;

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT)
    begin
      $display("Timeout, run still going after %0d cycles", cycles);
      $display("Test FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // Stimulus and checks
  initial
  begin
    test_t t;
    int    lat;
    logic  got;
    logic  ok;
    mem_req  <= 1'b0;
    mem_adr  <= '0;
    mem_size <= WORD;
    mem_type <= SINGLE;
    mem_prot <= '0;
    mem_we   <= 1'b0;
    mem_d    <= '0;
    build_table();
    @(posedge rst_n);
    // Outputs quiet until the first request
    repeat (3)
    begin
      @(negedge clk);
      assert (!mem_ack && !mem_err)
      else
      begin
        $display("Ack or error raised after reset with no request");
        errors++;
      end
    end
    for (int n = 0; n < N_TESTS; n++)
    begin
      t  = tests[n];
      ok = 1'b1;
      @(posedge clk);
      mem_req  <= 1'b1;
      mem_adr  <= t.adr;
      mem_size <= t.size;
      mem_type <= t.btype;
      mem_prot <= t.prot;
      mem_we   <= t.we;
      mem_d    <= t.d;
      lat = 0;
      got = 1'b0;
      // One cycle request, ack sampled mid-cycle
      while (!got && lat < 4)
      begin
        @(posedge clk);
        mem_req <= 1'b0;
        lat++;
        @(negedge clk);
        got = mem_ack;
      end
      assert (got)
      else
      begin
        $display("Entry %0d got no acknowledge within 4 cycles", n);
        ok = 1'b0;
      end
      if (got)
      begin
        assert (lat == t.exp_lat)
        else
        begin
          $display("Entry %0d acknowledged after %0d cycles instead of %0d", n, lat, t.exp_lat);
          ok = 1'b0;
        end
        assert (mem_err == t.exp_err)
        else
        begin
          $display("Fail entry %0d: mem_err_o = %h, expected %h", n, mem_err, t.exp_err);
          ok = 1'b0;
        end
        if (t.chk_q)
        begin
          assert (mem_q == t.exp_q)
          else
          begin
            $display("Fail entry %0d: mem_q_o = %h, expected %h", n, mem_q, t.exp_q);
            ok = 1'b0;
          end
        end
      end
      if (ok)
        passed++;
      else
        errors++;
      $display("entry %2d %s adr %h size %s type %s: %s", n, t.we ? "write" : "read ",
               t.adr, t.size.name(), t.btype.name(), ok ? "pass" : "error");
    end
    // Let stray acks show up before counting
    repeat (3) @(negedge clk);
    assert (ack_count == N_TESTS)
    else
    begin
      $display("Saw %0d acknowledges for %0d requests", ack_count, N_TESTS);
      errors++;
    end
    assert (data_mem_subsys_i.props_i.fail_count == 0)
    else
    begin
      $display("Bound handshake assertions failed %0d times",
               data_mem_subsys_i.props_i.fail_count);
      errors++;
    end
    $display("%0d entries, %0d passed, %0d failed, %0d errors in total",
             N_TESTS, passed, N_TESTS - passed, errors);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

/* data_mem_subsys.f */
biu_pkg.sv
biu_if.sv
axi_lite_if.sv
data_ext_access.sv
biu_axi_lite.sv
axi_lite_ram.sv
data_mem_subsys.sv
data_mem_subsys_properties.sv
tb_clk_gen.sv
data_mem_subsys_tb.sv
